// ==== calc_pkg.sv ====
package calc_pkg;

    // Byte and operand width
    localparam int DATA_W     = 8;
    // Opcode field sits in the low bits of the opcode byte
    localparam int OPCODE_W   = 6;

    // Queue depth must stay a power of two
    localparam int FIFO_DEPTH = 8;
    localparam int ADDR_W     = $clog2(FIFO_DEPTH);
    localparam int COUNT_W    = ADDR_W + 1;     // Holds 0..FIFO_DEPTH

    // Arithmetic group
    localparam logic [OPCODE_W-1:0] OP_ADD = 6'b100000;
    localparam logic [OPCODE_W-1:0] OP_SUB = 6'b100010;

    // Bitwise group
    localparam logic [OPCODE_W-1:0] OP_AND = 6'b100100;
    localparam logic [OPCODE_W-1:0] OP_OR  = 6'b100101;
    localparam logic [OPCODE_W-1:0] OP_XOR = 6'b100110;
    localparam logic [OPCODE_W-1:0] OP_NOR = 6'b100111;

    // Right shifts by the low three bits of B
    localparam logic [OPCODE_W-1:0] OP_SRL = 6'b000010;
    localparam logic [OPCODE_W-1:0] OP_SRA = 6'b000011;

    // Shift amount field width
    localparam int SHAMT_W = $clog2(DATA_W);

    // Frame controller states with one per received field plus compute and send
    typedef enum logic [2:0] {
        IDLE        = 3'b000,   // Waiting for opcode byte
        SAVE_OP1    = 3'b001,   // Waiting for operand A
        SAVE_OP2    = 3'b010,   // Waiting for operand B
        COMPUTE_ALU = 3'b011,   // Result latched here
        SEND_RESULT = 3'b100    // Push result to transmit queue
    } ctrl_state_t;

endpackage

// ==== alu_if.sv ====
interface alu_if;
    import calc_pkg::*;

    logic [DATA_W-1:0]   op_a;      // Operand A
    logic [DATA_W-1:0]   op_b;      // Operand B
    logic [OPCODE_W-1:0] op_code;   // Operation select
    logic [DATA_W-1:0]   result;    // Combinational from the operands

    // Frame controller side
    modport ctrl (
        output op_a,
        output op_b,
        output op_code,
        input  result
    );

    // ALU side
    modport alu (
        input  op_a,
        input  op_b,
        input  op_code,
        output result
    );

endinterface

// ==== byte_fifo.sv ====
module byte_fifo (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_wr,        // Push request
    input  logic [calc_pkg::DATA_W-1:0] i_wr_data,
    output logic                      o_full,
    input  logic                      i_rd,        // Pop request
    output logic [calc_pkg::DATA_W-1:0] o_rd_data, // Oldest entry while not empty
    output logic                      o_empty
);
    import calc_pkg::*;

    logic [DATA_W-1:0]  mem [FIFO_DEPTH];
    logic [ADDR_W-1:0]  wr_ptr;
    logic [ADDR_W-1:0]  rd_ptr;
    logic [COUNT_W-1:0] count;
    logic               wr_en;
    logic               rd_en;

    // Qualified handshakes
    assign wr_en = i_wr && !o_full;
    assign rd_en = i_rd && !o_empty;

    assign o_full    = (count == COUNT_W'(FIFO_DEPTH));
    assign o_empty   = (count == '0);
    assign o_rd_data = mem[rd_ptr];     // Fall-through read

    // Storage array
    always_ff @(posedge i_clk)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    // Pointers wrap on their own since depth is a power of two
    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Both sides of the queue are expected to look at the flags first
    a_no_write_when_full: assert property (
        @(posedge i_clk) disable iff (i_reset) i_wr |-> !o_full
    ) else $error("byte_fifo: write while full");

    a_no_read_when_empty: assert property (
        @(posedge i_clk) disable iff (i_reset) i_rd |-> !o_empty
    ) else $error("byte_fifo: read while empty");

endmodule

// ==== alu_arith.sv ====
module alu_arith (
    input  logic [calc_pkg::DATA_W-1:0] i_op_a,
    input  logic [calc_pkg::DATA_W-1:0] i_op_b,
    input  logic                        i_sub,   // 1 selects a - b
    output logic [calc_pkg::DATA_W-1:0] o_sum
);
    import calc_pkg::*;

    logic [DATA_W-1:0] b_eff;
    logic [DATA_W-1:0] carry_in;

    // Two's complement subtract through the same adder
    assign b_eff    = i_sub ? ~i_op_b : i_op_b;
    assign carry_in = DATA_W'(i_sub);

    // Carry out dropped so the sum wraps modulo 2**DATA_W
    assign o_sum = i_op_a + b_eff + carry_in;

endmodule

// ==== alu_logic.sv ====
module alu_logic (
    input  logic [calc_pkg::DATA_W-1:0]   i_op_a,
    input  logic [calc_pkg::DATA_W-1:0]   i_op_b,
    input  logic [calc_pkg::OPCODE_W-1:0] i_op_code,
    output logic [calc_pkg::DATA_W-1:0]   o_res
);
    import calc_pkg::*;

    logic [SHAMT_W-1:0] shamt;
    logic [DATA_W-1:0]  sra_res;

    assign shamt = i_op_b[SHAMT_W-1:0];   // Only low bits of B count

    // Sign bit fills from the left
    assign sra_res = DATA_W'($signed(i_op_a) >>> shamt);

    always_comb
    begin
        case (i_op_code)
            OP_AND:  o_res = i_op_a & i_op_b;
            OP_OR:   o_res = i_op_a | i_op_b;
            OP_XOR:  o_res = i_op_a ^ i_op_b;
            OP_NOR:  o_res = ~(i_op_a | i_op_b);
            OP_SRL:  o_res = i_op_a >> shamt;
            OP_SRA:  o_res = sra_res;
            default: o_res = '0;           // Not a logic/shift op
        endcase
    end

endmodule

// ==== alu_core.sv ====
module alu_core (
    alu_if.alu bus
);
    import calc_pkg::*;

    logic              sub_sel;
    logic              arith_sel;
    logic              logic_sel;
    logic [DATA_W-1:0] arith_res;
    logic [DATA_W-1:0] logic_res;

    // Opcode decode
    assign sub_sel   = (bus.op_code == OP_SUB);
    assign arith_sel = (bus.op_code == OP_ADD) || sub_sel;

    always_comb
    begin
        case (bus.op_code)
            OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SRL, OP_SRA: logic_sel = 1'b1;
            default:                                       logic_sel = 1'b0;
        endcase
    end

    // Both units run side by side
    alu_arith u_arith (
        .i_op_a (bus.op_a),
        .i_op_b (bus.op_b),
        .i_sub  (sub_sel),
        .o_sum  (arith_res)
    );

    alu_logic u_logic (
        .i_op_a    (bus.op_a),
        .i_op_b    (bus.op_b),
        .i_op_code (bus.op_code),
        .o_res     (logic_res)
    );

    // Unknown opcode gives zero
    always_comb
    begin
        if (arith_sel)
        begin
            bus.result = arith_res;
        end
        else if (logic_sel)
        begin
            bus.result = logic_res;
        end
        else
        begin
            bus.result = '0;
        end
    end

endmodule

// ==== uart_alu_interface.sv ====
module uart_alu_interface (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_rx_empty,  // Receive queue empty
    input  logic [calc_pkg::DATA_W-1:0] i_r_data,    // Head of receive queue
    output logic                        o_rd_uart,   // Pop from receive queue
    input  logic                        i_tx_full,   // Transmit queue full
    output logic [calc_pkg::DATA_W-1:0] o_w_data,    // Byte to transmit
    output logic                        o_wr_uart,   // Push to transmit queue
    alu_if.ctrl                         bus
);
    import calc_pkg::*;

    ctrl_state_t state_reg;
    ctrl_state_t state_next;

    // Frame fields and the latched result
    logic [OPCODE_W-1:0] opcode;
    logic [DATA_W-1:0]   op1;
    logic [DATA_W-1:0]   op2;
    logic [DATA_W-1:0]   result;

    logic capture_state;

    assign capture_state = (state_reg == IDLE) ||
                           (state_reg == SAVE_OP1) ||
                           (state_reg == SAVE_OP2);

    // One pop per field, only while a byte is waiting
    assign o_rd_uart = capture_state && !i_rx_empty;
    assign o_wr_uart = (state_reg == SEND_RESULT) && !i_tx_full;

    // State register
    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state_reg <= IDLE;
        end
        else
        begin
            state_reg <= state_next;
        end
    end

    // Next-state logic
    always_comb
    begin
        state_next = state_reg;
        case (state_reg)
            IDLE:
            begin
                if (!i_rx_empty)
                begin
                    state_next = SAVE_OP1;
                end
            end
            SAVE_OP1:
            begin
                if (!i_rx_empty)
                begin
                    state_next = SAVE_OP2;
                end
            end
            SAVE_OP2:
            begin
                if (!i_rx_empty)
                begin
                    state_next = COMPUTE_ALU;
                end
            end
            COMPUTE_ALU: state_next = SEND_RESULT;  // Always a single cycle
            SEND_RESULT:
            begin
                // Hold here under transmit back-pressure
                if (!i_tx_full)
                begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    // Datapath registers
    always_ff @(posedge i_clk)
    begin
        if (o_rd_uart && state_reg == IDLE)
        begin
            opcode <= i_r_data[OPCODE_W-1:0];   // Upper bits dropped
        end
        if (o_rd_uart && state_reg == SAVE_OP1)
        begin
            op1 <= i_r_data;
        end
        if (o_rd_uart && state_reg == SAVE_OP2)
        begin
            op2 <= i_r_data;
        end
        if (state_reg == COMPUTE_ALU)
        begin
            result <= bus.result;
        end
    end

    assign bus.op_code = opcode;
    assign bus.op_a    = op1;
    assign bus.op_b    = op2;
    assign o_w_data    = result;

    // A pop always moves the FSM on to the next field
    a_rd_advances: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_rd_uart |=> (state_reg != $past(state_reg))
    ) else $error("uart_alu_interface: pop without state advance");

    // A push ends the frame
    a_wr_ends_frame: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_wr_uart |=> (state_reg == IDLE)
    ) else $error("uart_alu_interface: push without return to IDLE");

endmodule

// ==== uart_alu_top.sv ====
module uart_alu_top (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic [calc_pkg::DATA_W-1:0] i_rx_data,   // Host byte in
    input  logic                        i_rx_wr,
    output logic                        o_rx_full,
    output logic [calc_pkg::DATA_W-1:0] o_tx_data,   // Result byte out
    output logic                        o_tx_valid,
    input  logic                        i_tx_rd
);
    import calc_pkg::*;

    logic              rx_empty;
    logic [DATA_W-1:0] rx_data;
    logic              rd_uart;
    logic              tx_full;
    logic              tx_empty;
    logic [DATA_W-1:0] w_data;
    logic              wr_uart;

    alu_if alu_bus ();

    byte_fifo rx_fifo (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_wr      (i_rx_wr),
        .i_wr_data (i_rx_data),
        .o_full    (o_rx_full),
        .i_rd      (rd_uart),
        .o_rd_data (rx_data),
        .o_empty   (rx_empty)
    );

    uart_alu_interface u_ctrl (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_rx_empty (rx_empty),
        .i_r_data   (rx_data),
        .o_rd_uart  (rd_uart),
        .i_tx_full  (tx_full),
        .o_w_data   (w_data),
        .o_wr_uart  (wr_uart),
        .bus        (alu_bus.ctrl)
    );

    alu_core u_alu (
        .bus (alu_bus.alu)
    );

    byte_fifo tx_fifo (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_wr      (wr_uart),
        .i_wr_data (w_data),
        .o_full    (tx_full),
        .i_rd      (i_tx_rd),
        .o_rd_data (o_tx_data),
        .o_empty   (tx_empty)
    );

    assign o_tx_valid = !tx_empty;   // Result waiting for the host

endmodule

// ==== tb_uart_alu.sv ====
module tb_uart_alu;
    import calc_pkg::*;

    localparam int          MAX_FRAMES  = 64;
    localparam int          STALL_AFTER = 4;              // Results popped before the long stall
    localparam int          STALL_HOLD  = 20;             // Extra cycles held once rx is full
    localparam logic [31:0] END_MARK    = 32'hffff_ffff;  // Empty slot in the frame table

    logic              i_clk;
    logic              i_reset;
    logic [DATA_W-1:0] i_rx_data;
    logic              i_rx_wr;
    logic              o_rx_full;
    logic [DATA_W-1:0] o_tx_data;
    logic              o_tx_valid;
    logic              i_tx_rd;

    // Opcode, A, B and expected result packed high to low
    logic [31:0] frame_mem [MAX_FRAMES];

    int num_frames;
    int byte_idx;      // Next byte for the writer
    int results;       // Results popped and checked
    int errors;
    int seed;
    int stall_phase;   // 0 none, 1 wait for rx full, 2 holding, 3 done
    int hold_cnt;
    bit saw_rx_full;
    bit loaded;
    bit running;

    uart_alu_top i_dut (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_rx_data  (i_rx_data),
        .i_rx_wr    (i_rx_wr),
        .o_rx_full  (o_rx_full),
        .o_tx_data  (o_tx_data),
        .o_tx_valid (o_tx_valid),
        .i_tx_rd    (i_tx_rd)
    );

    always #2 i_clk = ~i_clk;

    // Byte n of the stream with three bytes per frame
    function automatic logic [DATA_W-1:0] frame_byte(input int idx);
        logic [31:0] word;
        word = frame_mem[idx / 3];
        return word[31 - 8 * (idx % 3) -: 8];
    endfunction

    task automatic check_result(input logic [DATA_W-1:0] got);
        logic [31:0] word;
        word = frame_mem[results];
        if (got !== word[7:0])
        begin
            errors++;
            $display("[FAIL] %0t: frame %0d op %h a %h b %h gave %h, expected %h",
                     $time, results, word[31:24], word[23:16], word[15:8], got, word[7:0]);
        end
        results++;
    endtask

    // Writes go out every other cycle at most, so the full flag seen is current
    task automatic push_step();
        int gap;
        gap = $random(seed);
        if (i_rx_wr)
        begin
            i_rx_wr <= 1'b0;
        end
        else if (byte_idx < 3 * num_frames && !o_rx_full && gap[1:0] != 2'b00)
        begin
            i_rx_data <= frame_byte(byte_idx);
            i_rx_wr   <= 1'b1;
            byte_idx++;
        end
    endtask

    task automatic pop_step();
        int r;
        r = $random(seed);
        if (i_tx_rd)
        begin
            // Byte shown during the read cycle is the one popped on this edge
            check_result(o_tx_data);
            i_tx_rd <= 1'b0;
            if (results == STALL_AFTER && stall_phase == 0)
            begin
                stall_phase = 1;
            end
        end
        else if (stall_phase == 1)
        begin
            if (o_rx_full)
            begin
                saw_rx_full = 1'b1;
                hold_cnt    = STALL_HOLD;
                stall_phase = 2;
            end
        end
        else if (stall_phase == 2)
        begin
            hold_cnt--;
            if (hold_cnt == 0)
            begin
                stall_phase = 3;
            end
        end
        else if (o_tx_valid && results < num_frames && r[0])
        begin
            i_tx_rd <= 1'b1;
        end
    endtask

    // Both host sides from one process, so the random sequence is fixed
    always @(posedge i_clk)
    begin
        if (running)
        begin
            push_step();
            pop_step();
        end
    end

    initial
    begin
        i_clk       = 1'b0;
        i_reset     = 1'b1;
        i_rx_data   = '0;
        i_rx_wr     = 1'b0;
        i_tx_rd     = 1'b0;
        seed        = 32'hfa3c_0203;
        errors      = 0;
        results     = 0;
        byte_idx    = 0;
        stall_phase = 0;
        hold_cnt    = 0;
        saw_rx_full = 1'b0;
        running     = 1'b0;

        for (int i = 0; i < MAX_FRAMES; i++)
        begin
            frame_mem[i] = END_MARK;
        end
        $readmemh("alu_cases.txt", frame_mem);
        num_frames = 0;
        while (num_frames < MAX_FRAMES && frame_mem[num_frames] != END_MARK)
        begin
            num_frames++;
        end
        if (num_frames == 0)
        begin
            errors++;
            $display("No frames were read from alu_cases.txt");
        end
        loaded = 1'b1;

        repeat (10) @(posedge i_clk);
        i_reset <= 1'b0;
        @(posedge i_clk);

        // Both queues empty out of reset
        if (o_tx_valid !== 1'b0)
        begin
            errors++;
            $display("[FAIL] %0t: o_tx_valid is %b after reset, expected 0", $time, o_tx_valid);
        end
        if (o_rx_full !== 1'b0)
        begin
            errors++;
            $display("[FAIL] %0t: o_rx_full is %b after reset, expected 0", $time, o_rx_full);
        end
        running <= 1'b1;

        wait (results == num_frames);
        repeat (20) @(posedge i_clk);

        if (o_tx_valid)
        begin
            errors++;
            $display("An extra result byte %h is waiting after the last frame", o_tx_data);
        end
        if (num_frames > STALL_AFTER && !saw_rx_full)
        begin
            errors++;
            $display("The receive queue never reported full while the reader stalled");
        end

        $display("Errors: %0d, results: %0d of %0d frames", errors, results, num_frames);
        if (errors == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog scaled by the number of frames
    initial
    begin
        wait (loaded);
        repeat ((num_frames + 1) * 200) @(posedge i_clk);
        $display("Timeout: only %0d of %0d results arrived, the rest are missing",
                 results, num_frames);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== alu_cases.txt ====
// Columns: opcode byte _ operand A _ operand B _ expected result, all hex
// Opcode byte upper two bits are ignored, unknown opcodes give 00
20_05_03_08
20_f0_20_10
22_10_03_0d
22_03_05_fe
24_cc_aa_88
25_cc_aa_ee
26_cc_aa_66
27_cc_aa_11
02_b4_03_16
02_b4_0b_16
03_b4_02_ed
03_74_02_1d
03_80_ff_ff
15_12_34_00
e0_07_09_10
a2_09_07_02
c3_f0_01_f8
00_aa_55_00
27_00_00_ff
22_00_01_ff

// ==== project.f ====
calc_pkg.sv
alu_if.sv
byte_fifo.sv
alu_arith.sv
alu_logic.sv
alu_core.sv
uart_alu_interface.sv
uart_alu_top.sv
tb_uart_alu.sv

// ==== Makefile ====
TOP = tb_uart_alu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) \
		-Mdir obj_dir -o sim

run: compile
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
